//--- src/stq_config.svh
`ifndef STQ_CONFIG_SVH
`define STQ_CONFIG_SVH

// queue geometry
`define STQ_DEPTH     4

// datapath widths
`define STQ_ADDR_W    32
`define STQ_DATA_W    32

// rob commit tag
`define STQ_CMT_ID_W  6

`endif

//--- src/stq_pkg.sv
`default_nettype none

`include "stq_config.svh"

package stq_pkg;

  localparam int unsigned IDX_W = $clog2(`STQ_DEPTH);
  localparam int unsigned CNT_W = $clog2(`STQ_DEPTH + 1);

  typedef logic [IDX_W-1:0]           stq_idx_t;
  typedef logic [CNT_W-1:0]           stq_cnt_t;
  typedef logic [`STQ_ADDR_W-1:0]     stq_addr_t;
  typedef logic [`STQ_DATA_W-1:0]     stq_data_t;
  typedef logic [`STQ_DATA_W/8-1:0]   stq_be_t;
  typedef logic [`STQ_CMT_ID_W-1:0]   cmt_id_t;

  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2
  } stq_size_e;

  typedef enum logic [2:0] {
    ST_FREE,
    ST_WAIT_ADDR,
    ST_TLB_HAZ,
    ST_WAIT_COMMIT,
    ST_WAIT_DATA,   // committed without its store data
    ST_COMMIT,
    ST_DEAD
  } stq_state_e;

endpackage

`default_nettype wire

//--- src/stq_if.sv
`timescale 1ns/100ps
`default_nettype none

// single-cycle pipeline updates into the queue
interface stq_upd_if;

  logic                addr_valid;
  stq_pkg::stq_idx_t   addr_idx;
  stq_pkg::stq_addr_t  addr;
  stq_pkg::stq_size_e  size;
  logic                tlb_miss;
  logic                data_valid;
  stq_pkg::stq_idx_t   data_idx;
  stq_pkg::stq_data_t  data;

  modport ctrl  (input addr_valid, addr_idx, tlb_miss, data_valid, data_idx);
  modport store (input addr_valid, addr_idx, addr, size, data_valid, data_idx, data);

endinterface

// head entry towards the store buffer
interface stq_drain_if;

  stq_pkg::stq_idx_t   head_idx;
  logic                head_commit;
  stq_pkg::stq_addr_t  head_addr;
  stq_pkg::stq_size_e  head_size;
  stq_pkg::stq_data_t  head_data;
  logic                drained;

  modport ctrl  (output head_commit, input drained);
  modport store (input head_idx, output head_addr, head_size, head_data);
  modport drain (input head_commit, head_addr, head_size, head_data, output drained);

endinterface

`default_nettype wire

//--- src/stq_ptr_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "stq_config.svh"

module stq_ptr_ctrl (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_alloc,
  input  logic               i_retire,
  output stq_pkg::stq_idx_t  o_tail,
  output stq_pkg::stq_idx_t  o_head,
  output logic               o_full
);

  stq_pkg::stq_idx_t  r_head;
  stq_pkg::stq_idx_t  r_tail;
  stq_pkg::stq_cnt_t  r_cnt;

  // pointers wrap on overflow since the depth is a power of two
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head <= '0;
      r_tail <= '0;
      r_cnt  <= '0;
    end else begin
      if (i_alloc) begin
        r_tail <= r_tail + 1'b1;
      end
      if (i_retire) begin
        r_head <= r_head + 1'b1;
      end
      case ({i_alloc, i_retire})
        2'b10:   r_cnt <= r_cnt + 1'b1;
        2'b01:   r_cnt <= r_cnt - 1'b1;
        default: r_cnt <= r_cnt;  // idle or both at once
      endcase
    end
  end

  assign o_tail = r_tail;
  assign o_head = r_head;
  assign o_full = (r_cnt == stq_pkg::stq_cnt_t'(`STQ_DEPTH));

endmodule

`default_nettype wire

//--- src/stq_entry_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "stq_config.svh"

module stq_entry_ctrl (
  input  logic               i_clk,
  input  logic               i_reset_n,

  input  logic               i_alloc,
  input  stq_pkg::stq_idx_t  i_alloc_idx,
  input  stq_pkg::cmt_id_t   i_disp_cmt_id,

  input  logic               i_commit_valid,
  input  stq_pkg::cmt_id_t   i_commit_id,
  input  logic               i_flush,
  input  logic               i_tlb_resolve,

  input  stq_pkg::stq_idx_t  i_head,

  stq_upd_if.ctrl            upd_if,
  stq_drain_if.ctrl          drain_if,

  output logic               o_retire
);

  stq_pkg::stq_state_e  r_state      [`STQ_DEPTH];
  stq_pkg::stq_state_e  w_state_next [`STQ_DEPTH];
  stq_pkg::cmt_id_t     r_cmt_id     [`STQ_DEPTH];
  logic [`STQ_DEPTH-1:0] r_data_rdy;

  logic [`STQ_DEPTH-1:0] w_alloc_hit;
  logic [`STQ_DEPTH-1:0] w_addr_hit;
  logic [`STQ_DEPTH-1:0] w_data_hit;
  logic [`STQ_DEPTH-1:0] w_cmt_hit;
  logic [`STQ_DEPTH-1:0] w_data_ready;
  logic [`STQ_DEPTH-1:0] w_is_head;

  stq_pkg::stq_state_e  w_head_state;

  // ------------------------------
  // per-entry decode
  // ------------------------------
  always_comb begin
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      w_alloc_hit[i]  = i_alloc & (i_alloc_idx == stq_pkg::stq_idx_t'(i));
      w_addr_hit[i]   = upd_if.addr_valid & (upd_if.addr_idx == stq_pkg::stq_idx_t'(i));
      w_data_hit[i]   = upd_if.data_valid & (upd_if.data_idx == stq_pkg::stq_idx_t'(i));
      w_cmt_hit[i]    = i_commit_valid & (i_commit_id == r_cmt_id[i]);
      w_data_ready[i] = r_data_rdy[i] | w_data_hit[i];  // data may land with the commit
      w_is_head[i]    = (i_head == stq_pkg::stq_idx_t'(i));
    end
  end

  // ------------------------------
  // next state
  // ------------------------------
  always_comb begin
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      w_state_next[i] = r_state[i];
      case (r_state[i])
        stq_pkg::ST_FREE: begin
          if (w_alloc_hit[i]) begin
            w_state_next[i] = stq_pkg::ST_WAIT_ADDR;
          end
        end
        stq_pkg::ST_WAIT_ADDR: begin
          if (i_flush) begin
            w_state_next[i] = stq_pkg::ST_DEAD;
          end else if (w_addr_hit[i]) begin
            w_state_next[i] = upd_if.tlb_miss ? stq_pkg::ST_TLB_HAZ : stq_pkg::ST_WAIT_COMMIT;
          end
        end
        stq_pkg::ST_TLB_HAZ: begin
          if (i_flush) begin
            w_state_next[i] = stq_pkg::ST_DEAD;
          end else if (i_tlb_resolve) begin
            w_state_next[i] = stq_pkg::ST_WAIT_ADDR;  // replay the address write
          end
        end
        stq_pkg::ST_WAIT_COMMIT: begin
          if (i_flush) begin
            w_state_next[i] = stq_pkg::ST_DEAD;
          end else if (w_cmt_hit[i]) begin
            w_state_next[i] = w_data_ready[i] ? stq_pkg::ST_COMMIT : stq_pkg::ST_WAIT_DATA;
          end
        end
        stq_pkg::ST_WAIT_DATA: begin
          if (w_data_hit[i]) begin
            w_state_next[i] = stq_pkg::ST_COMMIT;
          end
        end
        stq_pkg::ST_COMMIT: begin
          if (w_is_head[i] & drain_if.drained) begin
            w_state_next[i] = stq_pkg::ST_FREE;
          end
        end
        stq_pkg::ST_DEAD: begin
          if (w_is_head[i]) begin
            w_state_next[i] = stq_pkg::ST_FREE;  // one release per cycle
          end
        end
        default: w_state_next[i] = stq_pkg::ST_FREE;
      endcase
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < `STQ_DEPTH; i++) begin
        r_state[i] <= stq_pkg::ST_FREE;
      end
      r_data_rdy <= '0;
    end else begin
      for (int i = 0; i < `STQ_DEPTH; i++) begin
        r_state[i] <= w_state_next[i];
      end
      r_data_rdy <= (r_data_rdy | w_data_hit) & ~w_alloc_hit;
    end
  end

  always_ff @(posedge i_clk) begin
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      if (w_alloc_hit[i]) begin
        r_cmt_id[i] <= i_disp_cmt_id;
      end
    end
  end

  // head status
  assign w_head_state         = r_state[i_head];
  assign drain_if.head_commit = (w_head_state == stq_pkg::ST_COMMIT);
  assign o_retire             = (w_head_state == stq_pkg::ST_DEAD) |
                                drain_if.head_commit & drain_if.drained;

endmodule

`default_nettype wire

//--- src/stq_entry_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "stq_config.svh"

module stq_entry_store (
  input  logic        i_clk,
  input  logic        i_reset_n,
  stq_upd_if.store    upd_if,
  stq_drain_if.store  drain_if
);

  stq_pkg::stq_addr_t  r_addr [`STQ_DEPTH];
  stq_pkg::stq_size_e  r_size [`STQ_DEPTH];
  stq_pkg::stq_data_t  r_data [`STQ_DEPTH];

  // size feeds the byte-enable decode
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < `STQ_DEPTH; i++) begin
        r_size[i] <= stq_pkg::SIZE_B;
      end
    end else if (upd_if.addr_valid) begin
      r_size[upd_if.addr_idx] <= upd_if.size;
    end
  end

  // rewritten on a tlb replay
  always_ff @(posedge i_clk) begin
    if (upd_if.addr_valid) begin
      r_addr[upd_if.addr_idx] <= upd_if.addr;
    end
  end

  always_ff @(posedge i_clk) begin
    if (upd_if.data_valid) begin
      r_data[upd_if.data_idx] <= upd_if.data;
    end
  end

  // ------------------------------
  // head read port
  // ------------------------------
  assign drain_if.head_addr = r_addr[drain_if.head_idx];
  assign drain_if.head_size = r_size[drain_if.head_idx];
  assign drain_if.head_data = r_data[drain_if.head_idx];

endmodule

`default_nettype wire

//--- src/stq_drain.sv
`timescale 1ns/100ps
`default_nettype none

`include "stq_config.svh"

module stq_drain (
  stq_drain_if.drain          drain_if,
  input  logic                i_stb_ready,
  output logic                o_stb_valid,
  output stq_pkg::stq_addr_t  o_stb_addr,
  output stq_pkg::stq_be_t    o_stb_be,
  output stq_pkg::stq_data_t  o_stb_data
);

  localparam int unsigned OFS_W = $clog2(`STQ_DATA_W / 8);

  logic [OFS_W-1:0]   w_ofs;
  stq_pkg::stq_be_t   w_be;

  assign w_ofs = drain_if.head_addr[OFS_W-1:0];

  // ------------------------------
  // byte lanes
  // ------------------------------
  always_comb begin
    case (drain_if.head_size)
      stq_pkg::SIZE_B: begin
        w_be = stq_pkg::stq_be_t'(1) << w_ofs;
      end
      stq_pkg::SIZE_H: begin
        w_be = stq_pkg::stq_be_t'(2'b11) << {w_ofs[OFS_W-1:1], 1'b0};  // halfword aligned
      end
      default: begin
        w_be = '1;
      end
    endcase
  end

  assign o_stb_valid = drain_if.head_commit;
  assign o_stb_addr  = {drain_if.head_addr[`STQ_ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
  assign o_stb_be    = w_be;
  assign o_stb_data  = drain_if.head_data << {w_ofs, 3'b000};  // move into its byte lane

  // accept edge
  assign drain_if.drained = drain_if.head_commit & i_stb_ready;

endmodule

`default_nettype wire

//--- src/stq_top.sv
`timescale 1ns/100ps
`default_nettype none

module stq_top (
  input  logic                i_clk,
  input  logic                i_reset_n,

  // dispatch
  input  logic                i_disp_valid,
  input  stq_pkg::cmt_id_t    i_disp_cmt_id,
  output logic                o_disp_ready,
  output stq_pkg::stq_idx_t   o_disp_idx,

  // address update
  input  logic                i_addr_valid,
  input  stq_pkg::stq_idx_t   i_addr_idx,
  input  stq_pkg::stq_addr_t  i_addr,
  input  stq_pkg::stq_size_e  i_size,
  input  logic                i_tlb_miss,
  input  logic                i_tlb_resolve,

  // store data
  input  logic                i_data_valid,
  input  stq_pkg::stq_idx_t   i_data_idx,
  input  stq_pkg::stq_data_t  i_data,

  // commit and flush
  input  logic                i_commit_valid,
  input  stq_pkg::cmt_id_t    i_commit_id,
  input  logic                i_flush,

  // store buffer
  output logic                o_stb_valid,
  output stq_pkg::stq_addr_t  o_stb_addr,
  output stq_pkg::stq_be_t    o_stb_be,
  output stq_pkg::stq_data_t  o_stb_data,
  input  logic                i_stb_ready
);

  logic               w_alloc;
  logic               w_retire;
  logic               w_full;
  stq_pkg::stq_idx_t  w_tail;
  stq_pkg::stq_idx_t  w_head;

  stq_upd_if    upd_if ();
  stq_drain_if  drain_if ();

  // ------------------------------
  // pipeline updates
  // ------------------------------
  assign upd_if.addr_valid = i_addr_valid;
  assign upd_if.addr_idx   = i_addr_idx;
  assign upd_if.addr       = i_addr;
  assign upd_if.size       = i_size;
  assign upd_if.tlb_miss   = i_tlb_miss;
  assign upd_if.data_valid = i_data_valid;
  assign upd_if.data_idx   = i_data_idx;
  assign upd_if.data       = i_data;

  assign w_alloc           = i_disp_valid & o_disp_ready;
  assign o_disp_ready      = ~w_full;
  assign o_disp_idx        = w_tail;
  assign drain_if.head_idx = w_head;

  stq_ptr_ctrl u_ptr_ctrl (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_alloc   (w_alloc),
    .i_retire  (w_retire),
    .o_tail    (w_tail),
    .o_head    (w_head),
    .o_full    (w_full)
  );

  stq_entry_ctrl u_entry_ctrl (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_alloc        (w_alloc),
    .i_alloc_idx    (w_tail),
    .i_disp_cmt_id  (i_disp_cmt_id),
    .i_commit_valid (i_commit_valid),
    .i_commit_id    (i_commit_id),
    .i_flush        (i_flush),
    .i_tlb_resolve  (i_tlb_resolve),
    .i_head         (w_head),
    .upd_if         (upd_if.ctrl),
    .drain_if       (drain_if.ctrl),
    .o_retire       (w_retire)
  );

  stq_entry_store u_entry_store (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .upd_if    (upd_if.store),
    .drain_if  (drain_if.store)
  );

  stq_drain u_drain (
    .drain_if    (drain_if.drain),
    .i_stb_ready (i_stb_ready),
    .o_stb_valid (o_stb_valid),
    .o_stb_addr  (o_stb_addr),
    .o_stb_be    (o_stb_be),
    .o_stb_data  (o_stb_data)
  );

endmodule

`default_nettype wire

//--- dv/stq_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "stq_config.svh"

module stq_tb;

  localparam int RESET_CYCLES = 16;
  localparam int TOTAL_TXN    = 60;  // stores over all tests
  localparam int MAX_STORES   = 64;

  logic                i_clk;
  logic                i_reset_n;
  logic                i_disp_valid;
  stq_pkg::cmt_id_t    i_disp_cmt_id;
  logic                o_disp_ready;
  stq_pkg::stq_idx_t   o_disp_idx;
  logic                i_addr_valid;
  stq_pkg::stq_idx_t   i_addr_idx;
  stq_pkg::stq_addr_t  i_addr;
  stq_pkg::stq_size_e  i_size;
  logic                i_tlb_miss;
  logic                i_tlb_resolve;
  logic                i_data_valid;
  stq_pkg::stq_idx_t   i_data_idx;
  stq_pkg::stq_data_t  i_data;
  logic                i_commit_valid;
  stq_pkg::cmt_id_t    i_commit_id;
  logic                i_flush;
  logic                o_stb_valid;
  stq_pkg::stq_addr_t  o_stb_addr;
  stq_pkg::stq_be_t    o_stb_be;
  stq_pkg::stq_data_t  o_stb_data;
  logic                i_stb_ready;

  int           seed       = 17;
  int           ready_seed = 17;
  int           ready_mode;  // 0 always ready, 1 random, 2 stalled
  logic [31:0]  ready_rnd;

  // ------------------------------
  // reference queue model
  // ------------------------------
  logic [31:0]         m_addr      [MAX_STORES];
  stq_pkg::stq_size_e  m_size      [MAX_STORES];
  logic [31:0]         m_data      [MAX_STORES];
  stq_pkg::cmt_id_t    m_cmt       [MAX_STORES];
  stq_pkg::stq_idx_t   m_idx       [MAX_STORES];
  bit                  m_committed [MAX_STORES];
  bit                  m_dead      [MAX_STORES];
  int                  model_q [$];  // store numbers in dispatch order
  int                  n_stores;
  int                  pending;      // committed but not yet drained
  stq_pkg::cmt_id_t    next_id;
  stq_pkg::stq_idx_t   m_tail;       // next entry the queue hands out

  string  test_name;
  int     errors;
  int     errors_at_start;
  int     tests_run;
  int     tests_failed;

  logic         hold_valid;
  logic [31:0]  held_addr;
  logic [3:0]   held_be;
  logic [31:0]  held_data;

  stq_top i_dut (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_disp_valid   (i_disp_valid),
    .i_disp_cmt_id  (i_disp_cmt_id),
    .o_disp_ready   (o_disp_ready),
    .o_disp_idx     (o_disp_idx),
    .i_addr_valid   (i_addr_valid),
    .i_addr_idx     (i_addr_idx),
    .i_addr         (i_addr),
    .i_size         (i_size),
    .i_tlb_miss     (i_tlb_miss),
    .i_tlb_resolve  (i_tlb_resolve),
    .i_data_valid   (i_data_valid),
    .i_data_idx     (i_data_idx),
    .i_data         (i_data),
    .i_commit_valid (i_commit_valid),
    .i_commit_id    (i_commit_id),
    .i_flush        (i_flush),
    .o_stb_valid    (o_stb_valid),
    .o_stb_addr     (o_stb_addr),
    .o_stb_be       (o_stb_be),
    .o_stb_data     (o_stb_data),
    .i_stb_ready    (i_stb_ready)
  );

  always #5 i_clk = ~i_clk;

  always @(negedge i_clk) begin
    if (ready_mode == 0) begin
      i_stb_ready = 1'b1;
    end else if (ready_mode == 1) begin
      ready_rnd   = $random(ready_seed);
      i_stb_ready = ready_rnd[0];
    end else begin
      i_stb_ready = 1'b0;
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("FAIL %s: expected %h, actual %h", name, exp_val, act_val);
      errors++;
    end
  endtask

  function automatic logic [3:0] lane_enables(input stq_pkg::stq_size_e sz,
                                              input logic [1:0] ofs);
    case (sz)
      stq_pkg::SIZE_B: lane_enables = 4'b0001 << ofs;
      stq_pkg::SIZE_H: lane_enables = ofs[1] ? 4'b1100 : 4'b0011;
      default:         lane_enables = 4'b1111;
    endcase
  endfunction

  task automatic compare_drain();
    int sn;
    logic [1:0] ofs;
    while (model_q.size() > 0 && m_dead[model_q[0]]) begin
      model_q.delete(0);  // flushed entries never reach the port
    end
    if (model_q.size() == 0 || !m_committed[model_q[0]]) begin
      $display("ERROR %s: store buffer received a store that was never committed",
               test_name);
      errors++;
    end else begin
      sn  = model_q.pop_front();
      ofs = m_addr[sn][1:0];
      check_value({test_name, " addr"}, {m_addr[sn][31:2], 2'b00}, o_stb_addr);
      check_value({test_name, " be"}, 32'(lane_enables(m_size[sn], ofs)), 32'(o_stb_be));
      check_value({test_name, " data"}, m_data[sn] << (8 * ofs), o_stb_data);
      pending--;
    end
  endtask

  // sampled before the edge updates anything
  always @(posedge i_clk) begin
    if (i_reset_n) begin
      if (hold_valid) begin
        check_value({test_name, " held valid"}, 32'd1, 32'(o_stb_valid));
        check_value({test_name, " held addr"}, held_addr, o_stb_addr);
        check_value({test_name, " held be"}, 32'(held_be), 32'(o_stb_be));
        check_value({test_name, " held data"}, held_data, o_stb_data);
      end
      hold_valid = o_stb_valid & ~i_stb_ready;
      held_addr  = o_stb_addr;
      held_be    = o_stb_be;
      held_data  = o_stb_data;
      if (o_stb_valid && i_stb_ready) begin
        compare_drain();
      end
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  task automatic gen_store(input int sn);
    logic [31:0] rnd;
    rnd = $random(seed);
    case (rnd[1:0])
      2'd0:    m_size[sn] = stq_pkg::SIZE_B;
      2'd1:    m_size[sn] = stq_pkg::SIZE_H;
      default: m_size[sn] = stq_pkg::SIZE_W;
    endcase
    rnd = $random(seed);
    if (m_size[sn] == stq_pkg::SIZE_H) rnd[0] = 1'b0;
    if (m_size[sn] == stq_pkg::SIZE_W) rnd[1:0] = 2'b00;
    m_addr[sn]      = rnd;
    m_data[sn]      = $random(seed);
    m_cmt[sn]       = next_id;
    next_id         = next_id + 1'b1;
    m_committed[sn] = 1'b0;
    m_dead[sn]      = 1'b0;
  endtask

  task automatic dispatch_store(input int sn);
    while (!o_disp_ready) @(negedge i_clk);
    i_disp_valid  = 1'b1;
    i_disp_cmt_id = m_cmt[sn];
    check_value({test_name, " disp idx"}, 32'(m_tail), 32'(o_disp_idx));
    m_idx[sn]     = m_tail;
    m_tail        = m_tail + 1'b1;
    model_q.push_back(sn);
    @(negedge i_clk);
    i_disp_valid = 1'b0;
  endtask

  task automatic alloc_only();
    gen_store(n_stores);
    dispatch_store(n_stores);
    n_stores++;
  endtask

  task automatic send_addr(input stq_pkg::stq_idx_t idx, input logic [31:0] addr,
                           input stq_pkg::stq_size_e sz, input logic miss);
    i_addr_valid = 1'b1;
    i_addr_idx   = idx;
    i_addr       = addr;
    i_size       = sz;
    i_tlb_miss   = miss;
    @(negedge i_clk);
    i_addr_valid = 1'b0;
    i_tlb_miss   = 1'b0;
  endtask

  task automatic send_data(input int sn);
    i_data_valid = 1'b1;
    i_data_idx   = m_idx[sn];
    i_data       = m_data[sn];
    @(negedge i_clk);
    i_data_valid = 1'b0;
  endtask

  task automatic send_commit(input int sn);
    i_commit_valid  = 1'b1;
    i_commit_id     = m_cmt[sn];
    m_committed[sn] = 1'b1;
    pending++;
    @(negedge i_clk);
    i_commit_valid = 1'b0;
  endtask

  task automatic pulse_resolve();
    i_tlb_resolve = 1'b1;
    @(negedge i_clk);
    i_tlb_resolve = 1'b0;
  endtask

  task automatic flush_queue();
    i_flush = 1'b1;
    foreach (model_q[k]) begin
      if (!m_committed[model_q[k]]) m_dead[model_q[k]] = 1'b1;
    end
    @(negedge i_clk);
    i_flush = 1'b0;
  endtask

  // mode 0 data first, 1 tlb miss and replay, 2 commit before data
  task automatic run_store(input int mode, input bit do_commit);
    int sn;
    logic [31:0] junk;
    sn = n_stores;
    n_stores++;
    gen_store(sn);
    dispatch_store(sn);
    if (mode == 1) begin
      junk = $random(seed);
      send_addr(m_idx[sn], {junk[31:2], 2'b11}, stq_pkg::SIZE_B, 1'b1);
      pulse_resolve();
    end
    send_addr(m_idx[sn], m_addr[sn], m_size[sn], 1'b0);
    if (mode == 2) begin
      if (do_commit) send_commit(sn);
      send_data(sn);
    end else begin
      send_data(sn);
      if (do_commit) send_commit(sn);
    end
  endtask

  // dead entries leave the head one per cycle
  task automatic wait_idle();
    while (pending > 0) @(negedge i_clk);
    repeat (`STQ_DEPTH) @(negedge i_clk);
    while (model_q.size() > 0 && m_dead[model_q[0]]) model_q.delete(0);
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  initial begin
    repeat (RESET_CYCLES + TOTAL_TXN * 50) @(posedge i_clk);
    $display("timeout: the store queue stopped making progress, run stopped");
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    logic [31:0] rnd;
    i_clk          = 1'b0;
    i_reset_n      = 1'b0;
    i_disp_valid   = 1'b0;
    i_disp_cmt_id  = '0;
    i_addr_valid   = 1'b0;
    i_addr_idx     = '0;
    i_addr         = '0;
    i_size         = stq_pkg::SIZE_B;
    i_tlb_miss     = 1'b0;
    i_tlb_resolve  = 1'b0;
    i_data_valid   = 1'b0;
    i_data_idx     = '0;
    i_data         = '0;
    i_commit_valid = 1'b0;
    i_commit_id    = '0;
    i_flush        = 1'b0;
    i_stb_ready    = 1'b0;
    ready_mode     = 0;
    hold_valid     = 1'b0;
    next_id        = '0;
    m_tail         = '0;
    repeat (RESET_CYCLES) @(negedge i_clk);
    i_reset_n = 1'b1;
    @(negedge i_clk);

    start_test("reset_and_full");
    check_value({test_name, " stb valid"}, 32'd0, 32'(o_stb_valid));
    check_value({test_name, " disp ready"}, 32'd1, 32'(o_disp_ready));
    repeat (4) alloc_only();
    check_value({test_name, " full"}, 32'd0, 32'(o_disp_ready));
    flush_queue();
    wait_idle();
    end_test();

    start_test("in_order_drain");
    repeat (5) begin
      ready_mode = 2;  // let a full queue of committed stores build up
      repeat (`STQ_DEPTH) begin
        rnd = $random(seed);
        run_store(rnd[0] ? 2 : 0, 1'b1);
      end
      ready_mode = 0;
      wait_idle();
    end
    end_test();

    start_test("backpressure");
    ready_mode = 1;
    repeat (20) begin
      rnd = $random(seed);
      run_store((rnd[1:0] == 2'd3) ? 0 : int'(rnd[1:0]), 1'b1);
    end
    wait_idle();
    end_test();

    start_test("tlb_replay");
    repeat (4) run_store(1, 1'b1);
    wait_idle();
    end_test();

    start_test("commit_before_data");
    ready_mode = 0;
    repeat (4) run_store(2, 1'b1);
    wait_idle();
    end_test();

    start_test("flush");
    ready_mode = 2;  // keep the committed ones parked
    run_store(0, 1'b1);
    run_store(0, 1'b1);
    run_store(0, 1'b0);
    run_store(2, 1'b0);
    flush_queue();
    ready_mode = 0;
    wait_idle();
    check_value({test_name, " stb idle"}, 32'd0, 32'(o_stb_valid));
    repeat (4) begin
      check_value({test_name, " ready before refill"}, 32'd1, 32'(o_disp_ready));
      alloc_only();
    end
    check_value({test_name, " full after refill"}, 32'd0, 32'(o_disp_ready));
    flush_queue();
    wait_idle();
    end_test();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- Makefile
VERILATOR ?= verilator
TOP       ?= stq_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Result: PASSED

.PHONY: sim clean

# build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb.f
+incdir+src
src/stq_pkg.sv
src/stq_if.sv
src/stq_ptr_ctrl.sv
src/stq_entry_ctrl.sv
src/stq_entry_store.sv
src/stq_drain.sv
src/stq_top.sv
dv/stq_tb.sv
